// File: hdl/cart_pkg.sv
// Loader widths, header word offsets, map mode codes, coprocessor codes and header word union
`default_nettype none

package cart_pkg;

	// ==============================
	// Widths
	// ==============================

	// Byte address into cartridge memory
	localparam int ROM_ADDR_W     = 24;
	localparam int HOST_ADDR_W    = 25;
	localparam int DATA_W         = 16;

	// Copier header is file size mod 1024
	localparam int SMC_ALIGN_BITS = 10;

	// ==============================
	// Internal cartridge header
	// ==============================

	// Word offsets inside the 32K header bank
	localparam logic [15:0] HDR_MAPPER_OFS  = 16'h7FD4;
	localparam logic [15:0] HDR_TYPE_OFS    = 16'h7FD6;
	localparam logic [15:0] HDR_RAM_OFS     = 16'h7FD8;
	localparam logic [15:0] HDR_COMPANY_OFS = 16'h7FDA;

	// Map modes, also the low bits of rom type
	localparam logic [1:0] MAP_LOROM   = 2'd0;
	localparam logic [1:0] MAP_HIROM   = 2'd1;
	localparam logic [1:0] MAP_EXHIROM = 2'd2;

	// Smallest ROM size the core ever decodes
	localparam logic [3:0] MIN_ROM_SIZE_CODE = 4'd12;
	// GSU carts always get 64K of RAM
	localparam logic [3:0] GSU_RAM_SIZE_CODE = 4'd6;

	// ==============================
	// Coprocessor codes, upper nibble of rom type
	// ==============================
	localparam logic [3:0] CHIP_CX4     = 4'h4;
	localparam logic [3:0] CHIP_SDD1    = 4'h5;
	localparam logic [3:0] CHIP_SA1     = 4'h6;
	localparam logic [3:0] CHIP_GSU     = 4'h7;
	localparam logic [3:0] CHIP_DSP1    = 4'h8;
	localparam logic [3:0] CHIP_DSP2    = 4'h9;
	localparam logic [3:0] CHIP_DSP3    = 4'hA;
	localparam logic [3:0] CHIP_DSP4    = 4'hB;
	localparam logic [3:0] CHIP_OBC1    = 4'hC;
	localparam logic [3:0] CHIP_SPC7110 = 4'hD;

	// Header word seen as two bytes, odd address in the high byte
	typedef struct packed {
		logic [7:0] hi;
		logic [7:0] lo;
	} hdr_bytes_t;

	// Same word at the type offset: rom size code above the cart type
	typedef struct packed {
		logic [3:0] spare;
		logic [3:0] rom_size;
		logic [7:0] cart_type;
	} hdr_info_t;

	typedef union packed {
		hdr_bytes_t bytes;
		hdr_info_t  info;
	} hdr_word_u;

endpackage

`default_nettype wire

// File: hdl/load_port.sv
// Host side four-phase slave with word capture and copier header removal
`timescale 1ns/100ps
`default_nettype none

module load_port #(
	parameter int ROM_ADDR_W = cart_pkg::ROM_ADDR_W
) (
	input  logic                             clk_sys,
	input  logic                             RESET_N,
	input  logic                             host_req,
	input  logic [cart_pkg::HOST_ADDR_W-1:0] host_addr,
	input  logic [cart_pkg::DATA_W-1:0]      host_data,
	input  logic [ROM_ADDR_W-1:0]            host_filesize,
	input  logic                             wr_ready,
	output logic                             host_ack,
	output logic                             word_valid,
	output logic [ROM_ADDR_W-1:0]            word_addr,
	output logic [cart_pkg::DATA_W-1:0]      word_data,
	output logic                             word_write
);
	import cart_pkg::*;

	logic [SMC_ALIGN_BITS-1:0] smc_ofs;
	logic [HOST_ADDR_W-1:0]    addr_adj;
	logic                      in_smc;
	logic                      pend;
	logic                      take;

	// Copier header length from the low file size bits
	assign smc_ofs  = host_filesize[SMC_ALIGN_BITS-1:0];
	assign addr_adj = host_addr - HOST_ADDR_W'(smc_ofs);
	assign in_smc   = host_addr < HOST_ADDR_W'(smc_ofs);

	// New request, not yet acked, and room downstream
	assign take = host_req && !host_ack && !pend && wr_ready;

	// ==============================
	// Handshake control
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (!RESET_N) begin
			pend       <= 1'b0;
			host_ack   <= 1'b0;
			word_valid <= 1'b0;
		end else begin
			word_valid <= 1'b0;
			if (take) begin
				pend <= 1'b1;
			end
			if (pend) begin
				// Word captured last cycle
				pend       <= 1'b0;
				host_ack   <= 1'b1;
				word_valid <= 1'b1;
			end else if (host_ack && !host_req) begin
				host_ack <= 1'b0;
			end
		end
	end

	// Captured word, qualified by word_valid
	always_ff @(posedge clk_sys) begin
		if (take) begin
			word_addr  <= addr_adj[ROM_ADDR_W-1:0];
			word_data  <= host_data;
			// Header words are acked but never stored
			word_write <= !in_smc;
		end
	end

endmodule

`default_nettype wire

// File: hdl/header_parser.sv
// Cartridge header field capture and ROM and RAM mask computation
`timescale 1ns/100ps
`default_nettype none

module header_parser (
	input  logic                            clk_sys,
	input  logic                            RESET_N,
	input  logic                            download,
	input  logic [1:0]                      map_mode,
	input  logic                            word_valid,
	input  logic [cart_pkg::ROM_ADDR_W-1:0] word_addr,
	input  logic [cart_pkg::DATA_W-1:0]     word_data,
	output logic [7:0]                      mapper,
	output logic [7:0]                      cart_type,
	output logic [3:0]                      rom_size,
	output logic [7:0]                      company,
	output logic [cart_pkg::ROM_ADDR_W-1:0] ram_mask_hdr,
	output logic [cart_pkg::ROM_ADDR_W-1:0] rom_mask,
	output logic [1:0]                      map_bits
);
	import cart_pkg::*;

	logic                  download_d;
	logic [3:0]            ram_size;
	logic [3:0]            rom_code;
	logic [ROM_ADDR_W-1:0] hdr_base;
	hdr_word_u             hw;
	logic                  hit_mapper;
	logic                  hit_type;
	logic                  hit_ram;
	logic                  hit_company;

	assign hw = word_data;

	// Header bank base per map mode
	always_comb begin
		case (map_bits)
			MAP_HIROM:   hdr_base = ROM_ADDR_W'(24'h008000);
			MAP_EXHIROM: hdr_base = ROM_ADDR_W'(24'h408000);
			default:     hdr_base = '0;
		endcase
	end

	assign hit_mapper  = word_addr == hdr_base + ROM_ADDR_W'(HDR_MAPPER_OFS);
	assign hit_type    = word_addr == hdr_base + ROM_ADDR_W'(HDR_TYPE_OFS);
	assign hit_ram     = word_addr == hdr_base + ROM_ADDR_W'(HDR_RAM_OFS);
	assign hit_company = word_addr == hdr_base + ROM_ADDR_W'(HDR_COMPANY_OFS);

	// ==============================
	// Field capture
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (!RESET_N) begin
			download_d <= 1'b0;
			map_bits   <= MAP_LOROM;
			ram_size   <= 4'd0;
			mapper     <= 8'd0;
			cart_type  <= 8'd0;
			rom_size   <= 4'd0;
			company    <= 8'd0;
		end else begin
			download_d <= download;
			// New image starts with no RAM
			if (download && !download_d) begin
				ram_size <= 4'd0;
				map_bits <= map_mode;
			end
			if (word_valid) begin
				if (hit_mapper) begin
					mapper <= hw.bytes.hi;
				end
				if (hit_type) begin
					rom_size  <= hw.info.rom_size;
					cart_type <= hw.info.cart_type;
				end
				if (hit_ram) begin
					ram_size <= hw.bytes.lo[3:0];
				end
				if (hit_company) begin
					company <= hw.bytes.lo;
				end
			end
		end
	end

	// Mask is 1K << size code, minus one
	assign rom_code = (rom_size < 4'd7) ? MIN_ROM_SIZE_CODE : rom_size;
	assign rom_mask = (ROM_ADDR_W'(1024) << rom_code) - ROM_ADDR_W'(1);

	// No RAM gives an empty mask
	assign ram_mask_hdr = (ram_size == 4'd0) ? '0 :
		(ROM_ADDR_W'(1024) << ram_size) - ROM_ADDR_W'(1);

endmodule

`default_nettype wire

// File: hdl/chip_detect.sv
// End of download coprocessor classification, final RAM mask and cart ready flag
`timescale 1ns/100ps
`default_nettype none

module chip_detect (
	input  logic                            clk_sys,
	input  logic                            RESET_N,
	input  logic                            download,
	input  logic [7:0]                      mapper,
	input  logic [7:0]                      cart_type,
	input  logic [3:0]                      rom_size,
	input  logic [7:0]                      company,
	input  logic [cart_pkg::ROM_ADDR_W-1:0] ram_mask_hdr,
	input  logic [1:0]                      map_bits,
	output logic [7:0]                      rom_type,
	output logic [cart_pkg::ROM_ADDR_W-1:0] ram_mask,
	output logic                            cart_ready
);
	import cart_pkg::*;

	// Fixed 64K RAM for GSU carts
	localparam logic [ROM_ADDR_W-1:0] GSU_RAM_MASK =
		(ROM_ADDR_W'(1024) << GSU_RAM_SIZE_CODE) - ROM_ADDR_W'(1);

	logic                  download_d;
	logic                  classified;
	logic [3:0]            chip_nib;
	logic                  type_bit3;
	logic                  is_gsu;

	// ==============================
	// Priority table
	// ==============================
	always_comb begin
		chip_nib  = 4'h0;
		type_bit3 = 1'b0;
		is_gsu    = 1'b0;
		if (mapper == 8'h30 && cart_type == 8'h05 && company == 8'hB2) begin
			chip_nib = CHIP_DSP3;
		end else if (((mapper == 8'h20 || mapper == 8'h21) && cart_type == 8'h03) ||
				(mapper == 8'h30 && cart_type == 8'h05) ||
				(mapper == 8'h31 && (cart_type == 8'h03 || cart_type == 8'h05))) begin
			chip_nib = CHIP_DSP1;
		end else if (mapper == 8'h20 && cart_type == 8'h05) begin
			chip_nib = CHIP_DSP2;
		end else if (mapper == 8'h30 && cart_type == 8'h03) begin
			chip_nib = CHIP_DSP4;
		end else if (mapper == 8'h30 && cart_type == 8'h25) begin
			chip_nib = CHIP_OBC1;
		end else if (mapper == 8'h32 && (cart_type == 8'h43 || cart_type == 8'h45)) begin
			chip_nib = CHIP_SDD1;
		end else if (mapper == 8'h30 && cart_type == 8'hF6) begin
			// ST0xx shares the DSP slot with bit 3 set and bit 5 for small ROMs
			chip_nib  = CHIP_DSP1 | ((rom_size < 4'd10) ? 4'b0010 : 4'b0000);
			type_bit3 = 1'b1;
		end else if (mapper == 8'h20 && (cart_type == 8'h13 || cart_type == 8'h14 ||
				cart_type == 8'h15 || cart_type == 8'h1A)) begin
			chip_nib = CHIP_GSU;
			is_gsu   = 1'b1;
		end else if (mapper == 8'h23 && (cart_type == 8'h32 || cart_type == 8'h34 ||
				cart_type == 8'h35)) begin
			chip_nib = CHIP_SA1;
		end else if (mapper == 8'h3A && (cart_type == 8'hF5 || cart_type == 8'hF9)) begin
			chip_nib  = CHIP_SPC7110;
			// RTC variant
			type_bit3 = cart_type[3];
		end else if (mapper == 8'h20 && cart_type == 8'hF3) begin
			chip_nib = CHIP_CX4;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!RESET_N) begin
			download_d <= 1'b0;
			classified <= 1'b0;
			rom_type   <= 8'd0;
			ram_mask   <= '0;
			cart_ready <= 1'b0;
		end else begin
			download_d <= download;
			classified <= 1'b0;
			if (download) begin
				cart_ready <= 1'b0;
			end else if (classified) begin
				cart_ready <= 1'b1;
			end
			// Download just ended
			if (download_d && !download) begin
				rom_type   <= {chip_nib, type_bit3, 1'b0, map_bits};
				ram_mask   <= is_gsu ? GSU_RAM_MASK : ram_mask_hdr;
				classified <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/rom_write_port.sv
// One word write buffer and memory side four-phase master
`timescale 1ns/100ps
`default_nettype none

module rom_write_port #(
	parameter int ROM_ADDR_W = cart_pkg::ROM_ADDR_W
) (
	input  logic                        clk_sys,
	input  logic                        RESET_N,
	input  logic                        word_valid,
	input  logic                        word_write,
	input  logic [ROM_ADDR_W-1:0]       word_addr,
	input  logic [cart_pkg::DATA_W-1:0] word_data,
	input  logic                        mem_ack,
	output logic                        wr_ready,
	output logic                        mem_req,
	output logic [ROM_ADDR_W-1:1]       mem_addr,
	output logic [cart_pkg::DATA_W-1:0] mem_data
);
	import cart_pkg::*;

	// FSM states
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_LOAD = 2'd1;
	localparam logic [1:0] ST_REQ  = 2'd2;
	localparam logic [1:0] ST_REL  = 2'd3;

	logic [1:0] state;
	logic       load;

	// Skipped header words never fill the buffer
	assign load     = (state == ST_IDLE) && word_valid && word_write;
	assign wr_ready = (state == ST_IDLE);

	always_ff @(posedge clk_sys) begin
		if (!RESET_N) begin
			state   <= ST_IDLE;
			mem_req <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (load) begin
						state <= ST_LOAD;
					end
				end
				ST_LOAD: begin
					mem_req <= 1'b1;
					state   <= ST_REQ;
				end
				ST_REQ: begin
					if (mem_ack) begin
						mem_req <= 1'b0;
						state   <= ST_REL;
					end
				end
				default: begin
					// Wait for the memory to release ack
					if (!mem_ack) begin
						state <= ST_IDLE;
					end
				end
			endcase
		end
	end

	// Word buffer, held through the whole memory handshake
	always_ff @(posedge clk_sys) begin
		if (load) begin
			mem_addr <= word_addr[ROM_ADDR_W-1:1];
			mem_data <= word_data;
		end
	end

endmodule

`default_nettype wire

// File: hdl/cart_loader_top.sv
// Cartridge loader top level connecting host port, header parser, chip detect and write port
`timescale 1ns/100ps
`default_nettype none

module cart_loader_top #(
	parameter int ROM_ADDR_W = cart_pkg::ROM_ADDR_W
) (
	input  logic                             clk_sys,
	input  logic                             RESET_N,
	input  logic                             download,
	input  logic [1:0]                       map_mode,
	input  logic [ROM_ADDR_W-1:0]            host_filesize,
	input  logic                             host_req,
	output logic                             host_ack,
	input  logic [cart_pkg::HOST_ADDR_W-1:0] host_addr,
	input  logic [cart_pkg::DATA_W-1:0]      host_data,
	output logic                             mem_req,
	input  logic                             mem_ack,
	output logic [ROM_ADDR_W-1:1]            mem_addr,
	output logic [cart_pkg::DATA_W-1:0]      mem_data,
	output logic [7:0]                       rom_type,
	output logic [cart_pkg::ROM_ADDR_W-1:0]  rom_mask,
	output logic [cart_pkg::ROM_ADDR_W-1:0]  ram_mask,
	output logic                             cart_ready
);
	import cart_pkg::*;

	// Captured word stream
	logic                  word_valid;
	logic                  word_write;
	logic [ROM_ADDR_W-1:0] word_addr;
	logic [DATA_W-1:0]     word_data;
	logic                  wr_ready;

	// Parsed header fields
	logic [7:0]            mapper;
	logic [7:0]            cart_type;
	logic [3:0]            rom_size;
	logic [7:0]            company;
	logic [ROM_ADDR_W-1:0] ram_mask_hdr;
	logic [1:0]            map_bits;

	load_port #(
		.ROM_ADDR_W(ROM_ADDR_W)
	) u_load_port (
		.clk_sys      (clk_sys),
		.RESET_N      (RESET_N),
		.host_req     (host_req),
		.host_addr    (host_addr),
		.host_data    (host_data),
		.host_filesize(host_filesize),
		.wr_ready     (wr_ready),
		.host_ack     (host_ack),
		.word_valid   (word_valid),
		.word_addr    (word_addr),
		.word_data    (word_data),
		.word_write   (word_write)
	);

	header_parser u_header_parser (
		.clk_sys     (clk_sys),
		.RESET_N     (RESET_N),
		.download    (download),
		.map_mode    (map_mode),
		.word_valid  (word_valid),
		.word_addr   (word_addr),
		.word_data   (word_data),
		.mapper      (mapper),
		.cart_type   (cart_type),
		.rom_size    (rom_size),
		.company     (company),
		.ram_mask_hdr(ram_mask_hdr),
		.rom_mask    (rom_mask),
		.map_bits    (map_bits)
	);

	chip_detect u_chip_detect (
		.clk_sys     (clk_sys),
		.RESET_N     (RESET_N),
		.download    (download),
		.mapper      (mapper),
		.cart_type   (cart_type),
		.rom_size    (rom_size),
		.company     (company),
		.ram_mask_hdr(ram_mask_hdr),
		.map_bits    (map_bits),
		.rom_type    (rom_type),
		.ram_mask    (ram_mask),
		.cart_ready  (cart_ready)
	);

	rom_write_port #(
		.ROM_ADDR_W(ROM_ADDR_W)
	) u_rom_write_port (
		.clk_sys   (clk_sys),
		.RESET_N   (RESET_N),
		.word_valid(word_valid),
		.word_write(word_write),
		.word_addr (word_addr),
		.word_data (word_data),
		.mem_ack   (mem_ack),
		.wr_ready  (wr_ready),
		.mem_req   (mem_req),
		.mem_addr  (mem_addr),
		.mem_data  (mem_data)
	);

endmodule

`default_nettype wire

// File: tb/tb_clock.sv
// Free running clock source for the loader testbench
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 20
) (
	output logic clk_sys
);

	initial begin
		clk_sys = 1'b0;
	end

	// Half period per edge
	always #(PERIOD / 2) clk_sys = ~clk_sys;

endmodule

`default_nettype wire

// File: tb/cart_loader_checker.sv
// Host and memory handshake assertions and cart ready rule for the loader top level
`timescale 1ns/100ps
`default_nettype none

module cart_loader_checker (
	input logic                            clk_sys,
	input logic                            RESET_N,
	input logic                            download,
	input logic                            host_req,
	input logic                            host_ack,
	input logic                            mem_req,
	input logic                            mem_ack,
	input logic [cart_pkg::ROM_ADDR_W-1:1] mem_addr,
	input logic [cart_pkg::DATA_W-1:0]     mem_data,
	input logic                            cart_ready
);

	// Failed properties so far
	int fail_count = 0;

	// ==============================
	// Memory side
	// ==============================
	mem_req_held: assert property (@(posedge clk_sys) disable iff (!RESET_N)
		mem_req && !mem_ack |=> mem_req)
	else begin
		fail_count++;
		$error("mem_req dropped before mem_ack arrived");
	end

	// Buffer must not move under an open request
	mem_word_stable: assert property (@(posedge clk_sys) disable iff (!RESET_N)
		mem_req |=> !mem_req || ($stable(mem_addr) && $stable(mem_data)))
	else begin
		fail_count++;
		$error("mem_addr or mem_data changed while mem_req was high");
	end

	// ==============================
	// Host side
	// ==============================
	host_ack_needs_req: assert property (@(posedge clk_sys) disable iff (!RESET_N)
		$rose(host_ack) |-> $past(host_req))
	else begin
		fail_count++;
		$error("host_ack rose without host_req");
	end

	host_ack_held: assert property (@(posedge clk_sys) disable iff (!RESET_N)
		host_ack && host_req |=> host_ack)
	else begin
		fail_count++;
		$error("host_ack dropped while host_req was still high");
	end

	// Cart ready only between downloads
	ready_after_download: assert property (@(posedge clk_sys) disable iff (!RESET_N)
		download |=> !cart_ready)
	else begin
		fail_count++;
		$error("cart_ready high during a download");
	end

endmodule

`default_nettype wire

// File: tb/cart_loader_tb.sv
// Loader testbench with host and memory models, result checks, watchdog and summary
`timescale 1ns/100ps
`default_nettype none

module cart_loader_tb;
	import cart_pkg::*;

	localparam logic [31:0] SEED = 32'h6a49858c;

	logic                   clk_sys;
	logic                   RESET_N;
	logic                   download;
	logic [1:0]             map_mode;
	logic [ROM_ADDR_W-1:0]  host_filesize;
	logic                   host_req;
	logic                   host_ack;
	logic [HOST_ADDR_W-1:0] host_addr;
	logic [DATA_W-1:0]      host_data;
	logic                   mem_req;
	logic                   mem_ack;
	logic [ROM_ADDR_W-1:1]  mem_addr;
	logic [DATA_W-1:0]      mem_data;
	logic [7:0]             rom_type;
	logic [ROM_ADDR_W-1:0]  rom_mask;
	logic [ROM_ADDR_W-1:0]  ram_mask;
	logic                   cart_ready;

	// Words still owed a memory write in send order
	logic [ROM_ADDR_W-1:1]  exp_addr[$];
	logic [DATA_W-1:0]      exp_data[$];
	logic [HOST_ADDR_W-1:0] cur_ofs = '0;
	int                     words_sent = 0;
	int                     writes_seen = 0;
	int                     cycles = 0;
	int                     mem_errs = 0;
	int                     result_errs = 0;
	int                     proto_errs = 0;

	tb_clock #(.PERIOD(20)) u_clock (.clk_sys(clk_sys));

	cart_loader_top #(.ROM_ADDR_W(ROM_ADDR_W)) UUT (.*);

	bind cart_loader_top cart_loader_checker u_checker (
		.clk_sys   (clk_sys),
		.RESET_N   (RESET_N),
		.download  (download),
		.host_req  (host_req),
		.host_ack  (host_ack),
		.mem_req   (mem_req),
		.mem_ack   (mem_ack),
		.mem_addr  (mem_addr),
		.mem_data  (mem_data),
		.cart_ready(cart_ready)
	);

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] want);
		assert (got == want) else begin
			result_errs++;
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, want);
		end
	endtask

	// Ones in every bit below 10 plus the size code
	function automatic logic [ROM_ADDR_W-1:0] size_mask(input logic [3:0] code);
		logic [ROM_ADDR_W-1:0] mask;
		mask = '0;
		for (int b = 0; b < ROM_ADDR_W; b++) begin
			if (b < 10 + int'(code)) begin
				mask[b] = 1'b1;
			end
		end
		return mask;
	endfunction

	// ==============================
	// Expected chip code with table order as priority
	// ==============================
	function automatic logic [7:0] expect_rom_type(input logic [1:0] mode,
			input logic [7:0] mp, input logic [7:0] ct, input logic [3:0] rs,
			input logic [7:0] co);
		logic [3:0] chip;
		logic       bit3;
		chip = 4'h0;
		bit3 = 1'b0;
		if (mp == 8'h30 && ct == 8'h05 && co == 8'hB2) begin
			chip = CHIP_DSP3;
		end else if ((mp inside {8'h20, 8'h21} && ct == 8'h03) ||
				(mp == 8'h30 && ct == 8'h05) || (mp == 8'h31 && ct inside {8'h03, 8'h05})) begin
			chip = CHIP_DSP1;
		end else if (mp == 8'h20 && ct == 8'h05) begin
			chip = CHIP_DSP2;
		end else if (mp == 8'h30 && ct == 8'h03) begin
			chip = CHIP_DSP4;
		end else if (mp == 8'h30 && ct == 8'h25) begin
			chip = CHIP_OBC1;
		end else if (mp == 8'h32 && ct inside {8'h43, 8'h45}) begin
			chip = CHIP_SDD1;
		end else if (mp == 8'h30 && ct == 8'hF6) begin
			// ST0xx sets bit 5 of the code for small ROMs
			chip = 4'h8;
			bit3 = 1'b1;
			if (rs < 4'd10) begin
				chip[1] = 1'b1;
			end
		end else if (mp == 8'h20 && ct inside {8'h13, 8'h14, 8'h15, 8'h1A}) begin
			chip = CHIP_GSU;
		end else if (mp == 8'h23 && ct inside {8'h32, 8'h34, 8'h35}) begin
			chip = CHIP_SA1;
		end else if (mp == 8'h3A && ct inside {8'hF5, 8'hF9}) begin
			chip = CHIP_SPC7110;
			bit3 = ct[3];
		end else if (mp == 8'h20 && ct == 8'hF3) begin
			chip = CHIP_CX4;
		end
		return {chip, bit3, 1'b0, mode};
	endfunction

	// ==============================
	// Host model
	// ==============================
	task automatic send_word(input logic [HOST_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		logic [HOST_ADDR_W-1:0] adj;
		host_addr = addr;
		host_data = data;
		host_req  = 1'b1;
		words_sent++;
		// Copier header words never reach memory
		if (addr >= cur_ofs) begin
			adj = addr - cur_ofs;
			exp_addr.push_back(adj[ROM_ADDR_W-1:1]);
			exp_data.push_back(data);
		end
		do begin
			@(negedge clk_sys);
		end while (!host_ack);
		host_req = 1'b0;
		do begin
			@(negedge clk_sys);
		end while (host_ack);
	endtask

	task automatic begin_download(input logic [1:0] mode, input logic [ROM_ADDR_W-1:0] fsize);
		map_mode      = mode;
		host_filesize = fsize;
		cur_ofs       = HOST_ADDR_W'(fsize % ROM_ADDR_W'(1024));
		download      = 1'b1;
		@(negedge clk_sys);
	endtask

	task automatic end_download;
		int waited;
		waited = 0;
		while (exp_addr.size() != 0) begin
			@(negedge clk_sys);
		end
		download = 1'b0;
		do begin
			@(negedge clk_sys);
			waited++;
		end while (!cart_ready);
		check_value("cart_ready latency", 32'(waited), 32'd2);
	endtask

	task automatic load_header(input logic [1:0] mode, input logic [7:0] mp,
			input logic [7:0] ct, input logic [3:0] rs, input logic [3:0] ram,
			input logic [7:0] co);
		logic [HOST_ADDR_W-1:0] base;
		hdr_word_u              w;
		logic [7:0]             want_type;
		logic [ROM_ADDR_W-1:0]  want_ram;
		case (mode)
			MAP_HIROM:   base = 25'h008000;
			MAP_EXHIROM: base = 25'h408000;
			default:     base = '0;
		endcase
		begin_download(mode, 24'h100000);
		w = '0;
		w.bytes.hi = mp;
		send_word(base + HOST_ADDR_W'(HDR_MAPPER_OFS), w);
		w = '0;
		w.info.rom_size  = rs;
		w.info.cart_type = ct;
		send_word(base + HOST_ADDR_W'(HDR_TYPE_OFS), w);
		w = '0;
		w.bytes.lo = {4'h0, ram};
		send_word(base + HOST_ADDR_W'(HDR_RAM_OFS), w);
		w = '0;
		w.bytes.lo = co;
		send_word(base + HOST_ADDR_W'(HDR_COMPANY_OFS), w);
		end_download();
		want_type = expect_rom_type(mode, mp, ct, rs, co);
		if (want_type[7:4] == CHIP_GSU) begin
			want_ram = size_mask(GSU_RAM_SIZE_CODE);
		end else if (ram == 4'd0) begin
			want_ram = '0;
		end else begin
			want_ram = size_mask(ram);
		end
		check_value("rom_type", 32'(rom_type), 32'(want_type));
		check_value("rom_mask", 32'(rom_mask),
			32'(size_mask((rs < 4'd7) ? MIN_ROM_SIZE_CODE : rs)));
		check_value("ram_mask", 32'(ram_mask), 32'(want_ram));
	endtask

	// ==============================
	// Memory model with random ack delay
	// ==============================
	function automatic void check_write;
		logic [ROM_ADDR_W-1:1] want_addr;
		logic [DATA_W-1:0]     want_data;
		writes_seen++;
		assert (exp_addr.size() != 0) else begin
			mem_errs++;
			$display("Memory write to word address %h arrived with no word pending", mem_addr);
		end
		if (exp_addr.size() != 0) begin
			want_addr = exp_addr.pop_front();
			want_data = exp_data.pop_front();
			assert (mem_addr == want_addr) else begin
				mem_errs++;
				$display("ERR %0t: mem_addr is %h, expected %h", $time, mem_addr, want_addr);
			end
			assert (mem_data == want_data) else begin
				mem_errs++;
				$display("ERR %0t: mem_data is %h, expected %h", $time, mem_data, want_data);
			end
		end
	endfunction

	initial begin : memory_model
		int unsigned delay;
		mem_ack = 1'b0;
		void'($urandom(SEED));
		forever begin
			@(negedge clk_sys);
			if (mem_req && !mem_ack) begin
				check_write();
				delay = $urandom_range(6, 0);
				repeat (delay) @(negedge clk_sys);
				mem_ack = 1'b1;
				while (mem_req) begin
					@(negedge clk_sys);
				end
				mem_ack = 1'b0;
			end
		end
	end

	// 40 cycles per word plus setup
	initial begin : watchdog
		while (cycles < 40 * words_sent + 200) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("Timeout after %0d cycles, %0d words never written", cycles, exp_addr.size());
		$display(">>> FAIL");
		$finish;
	end

	// ==============================
	// Stimulus
	// ==============================
	initial begin : stimulus
		logic [HOST_ADDR_W-1:0] addr;
		download      = 1'b0;
		map_mode      = MAP_LOROM;
		host_filesize = '0;
		host_req      = 1'b0;
		host_addr     = '0;
		host_data     = '0;
		RESET_N       = 1'b0;
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		RESET_N = 1'b1;
		check_value("idle ack, req, ready", 32'({host_ack, mem_req, cart_ready}), 32'd0);

		// Plain image of sparse words against a slow memory
		begin_download(MAP_LOROM, 24'h080000);
		for (int i = 0; i < 16; i++) begin
			addr = HOST_ADDR_W'(i) * 25'h002468 + 25'h000100;
			send_word(addr, 16'(addr ^ (addr >> 7)) ^ 16'hA5C3);
		end
		end_download();

		// 512 byte copier header in front
		begin_download(MAP_LOROM, 24'h000600);
		send_word(25'h000000, 16'h5343);
		send_word(25'h000002, 16'h0001);
		send_word(25'h0001FE, 16'hFFFF);
		send_word(25'h000200, 16'h1234);
		send_word(25'h000202, 16'h5678);
		send_word(25'h008200, 16'h9ABC);
		end_download();

		// Mask rules per map mode
		load_header(MAP_LOROM, 8'h20, 8'h02, 4'd5, 4'd0, 8'h01);
		load_header(MAP_HIROM, 8'h21, 8'h00, 4'd9, 4'd3, 8'h01);
		load_header(MAP_EXHIROM, 8'h35, 8'h02, 4'd11, 4'd5, 8'h33);

		// New image without a RAM word starts with no RAM
		begin_download(MAP_LOROM, 24'h080000);
		send_word(25'h000100, 16'h0F0F);
		end_download();
		check_value("ram_mask with no RAM word", 32'(ram_mask), 32'd0);

		// Coprocessor table
		load_header(MAP_HIROM, 8'h21, 8'h03, 4'd10, 4'd1, 8'h01);
		load_header(MAP_LOROM, 8'h30, 8'h05, 4'd9, 4'd0, 8'hB2);
		load_header(MAP_LOROM, 8'h30, 8'h05, 4'd9, 4'd0, 8'h33);
		load_header(MAP_LOROM, 8'h30, 8'hF6, 4'd9, 4'd0, 8'h33);
		load_header(MAP_LOROM, 8'h30, 8'hF6, 4'd10, 4'd0, 8'h33);
		load_header(MAP_HIROM, 8'h3A, 8'hF9, 4'd12, 4'd1, 8'h33);
		load_header(MAP_LOROM, 8'h20, 8'h15, 4'd10, 4'd2, 8'h33);
		load_header(MAP_LOROM, 8'h23, 8'h35, 4'd11, 4'd3, 8'h33);
		load_header(MAP_LOROM, 8'h32, 8'h45, 4'd12, 4'd0, 8'h33);
		load_header(MAP_LOROM, 8'h20, 8'hF3, 4'd10, 4'd0, 8'h33);
		load_header(MAP_HIROM, 8'h55, 8'h03, 4'd10, 4'd0, 8'h33);

		repeat (4) @(negedge clk_sys);
		proto_errs = UUT.u_checker.fail_count;
		$display("Errors: %0d memory, %0d result, %0d protocol (%0d words sent, %0d written)",
			mem_errs, result_errs, proto_errs, words_sent, writes_seen);
		if (mem_errs == 0 && result_errs == 0 && proto_errs == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
hdl/cart_pkg.sv
hdl/load_port.sv
hdl/header_parser.sv
hdl/chip_detect.sv
hdl/rom_write_port.sv
hdl/cart_loader_top.sv
tb/tb_clock.sv
tb/cart_loader_checker.sv
tb/cart_loader_tb.sv

// File: Makefile
SIM      = verilator
TOP      = cart_loader_tb
FILELIST = filelist.f
FLAGS    = --binary --timing --assert -j 0 --timescale 1ns/100ps
RUN_ARGS = +verilator+error+limit+100
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)

run: $(BIN)
	./$(BIN) $(RUN_ARGS) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
